/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_core_pkg.sv
      - hw/decoder.sv
      - hw/reg_file.sv
      - hw/hazard_unit.sv
      - hw/alu.sv
      - hw/rv_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/core_checker.sv
      - sim/tb_rv_core.sv

/* build.f */
+incdir+hw
hw/rv_core_pkg.sv
hw/decoder.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/alu.sv
hw/rv_core.sv
sim/core_checker.sv
sim/tb_rv_core.sv

/* hw/alu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_macros.svh"

module alu (
	input  wire [`XLEN-1:0]           a,
	input  wire [`XLEN-1:0]           b,
	input  wire rv_core_pkg::alu_op_e op,
	output logic [`XLEN-1:0]          result
);

	logic less;

	// signed compare for slt
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			rv_core_pkg::ALU_SUB: result = a - b;
			rv_core_pkg::ALU_AND: result = a & b;
			rv_core_pkg::ALU_OR:  result = a | b;
			rv_core_pkg::ALU_XOR: result = a ^ b;
			rv_core_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, less};
			// add also forms load and store addresses
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

/* hw/decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_macros.svh"

module decoder (
	input  wire [`XLEN-1:0]       instr,
	output logic [`REG_ADDR_W-1:0] rs1,
	output logic [`REG_ADDR_W-1:0] rs2,
	output logic [`REG_ADDR_W-1:0] rd,
	output logic [`XLEN-1:0]       imm,
	output rv_core_pkg::alu_op_e   alu_op,
	output logic                   use_imm,
	output logic                   reg_write,
	output logic                   mem_read,
	output logic                   mem_write
);

	rv_core_pkg::opcode_e opcode;
	logic [2:0] funct3;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;

	assign funct3 = instr[14:12];
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

	// unknown major opcodes all fold into OPC_OTHER
	always_comb begin
		case (instr[6:0])
			rv_core_pkg::OPC_OP,
			rv_core_pkg::OPC_OP_IMM,
			rv_core_pkg::OPC_LOAD,
			rv_core_pkg::OPC_STORE: opcode = rv_core_pkg::opcode_e'(instr[6:0]);
			default: opcode = rv_core_pkg::OPC_OTHER;
		endcase
	end

	// unused source and destination fields are zeroed so they never match
	always_comb begin
		rs1 = instr[19:15];
		rs2 = instr[24:20];
		rd = instr[11:7];
		imm = imm_i;
		alu_op = rv_core_pkg::ALU_ADD;
		use_imm = 1'b0;
		reg_write = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		case (opcode)
			rv_core_pkg::OPC_OP: begin
				case (funct3)
					3'b000: alu_op = instr[30] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
					3'b010: alu_op = rv_core_pkg::ALU_SLT;
					3'b100: alu_op = rv_core_pkg::ALU_XOR;
					3'b110: alu_op = rv_core_pkg::ALU_OR;
					3'b111: alu_op = rv_core_pkg::ALU_AND;
					default: reg_write = 1'b0;
				endcase
			end
			rv_core_pkg::OPC_OP_IMM: begin
				rs2 = '0;
				use_imm = 1'b1;
				// only addi is supported
				reg_write = (funct3 == 3'b000);
			end
			rv_core_pkg::OPC_LOAD: begin
				rs2 = '0;
				use_imm = 1'b1;
				mem_read = 1'b1;
			end
			rv_core_pkg::OPC_STORE: begin
				rd = '0;
				imm = imm_s;
				use_imm = 1'b1;
				reg_write = 1'b0;
				mem_write = 1'b1;
			end
			default: begin
				rs1 = '0;
				rs2 = '0;
				rd = '0;
				reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_macros.svh"

module hazard_unit (
	input  wire [`REG_ADDR_W-1:0]  id_rs1,
	input  wire [`REG_ADDR_W-1:0]  id_rs2,
	input  wire [`REG_ADDR_W-1:0]  ex_rs1,
	input  wire [`REG_ADDR_W-1:0]  ex_rs2,
	input  wire [`REG_ADDR_W-1:0]  ex_rd,
	input  wire                    ex_mem_read,
	input  wire [`REG_ADDR_W-1:0]  mem_rd,
	input  wire                    mem_reg_write,
	input  wire                    mem_mem_read,
	input  wire [`REG_ADDR_W-1:0]  wb_rd,
	input  wire                    wb_reg_write,
	output logic                   stall,
	output rv_core_pkg::fwd_sel_e  fwd_a,
	output rv_core_pkg::fwd_sel_e  fwd_b
);

	logic mem_fwd_ok;
	logic wb_fwd_ok;

	// a load in memory has no result yet, the stall covers that case
	assign mem_fwd_ok = mem_reg_write && !mem_mem_read && (mem_rd != '0);
	assign wb_fwd_ok = wb_reg_write && (wb_rd != '0);

	// load-use: hold decode one cycle until the load reaches writeback
	assign stall = ex_mem_read && (ex_rd != '0) && ((ex_rd == id_rs1) || (ex_rd == id_rs2));

	function automatic rv_core_pkg::fwd_sel_e pick_src(
		input logic [`REG_ADDR_W-1:0] src,
		input logic                   mem_ok,
		input logic [`REG_ADDR_W-1:0] mem_dst,
		input logic                   wb_ok,
		input logic [`REG_ADDR_W-1:0] wb_dst
	);
		// the younger result wins
		if (mem_ok && (mem_dst == src))
			pick_src = rv_core_pkg::FWD_EX_MEM;
		else if (wb_ok && (wb_dst == src))
			pick_src = rv_core_pkg::FWD_WB;
		else
			pick_src = rv_core_pkg::FWD_RF;
	endfunction

	assign fwd_a = pick_src(ex_rs1, mem_fwd_ok, mem_rd, wb_fwd_ok, wb_rd);
	assign fwd_b = pick_src(ex_rs2, mem_fwd_ok, mem_rd, wb_fwd_ok, wb_rd);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_macros.svh"

module reg_file (
	input  wire                    clock,
	input  wire                    reset,
	input  wire [`REG_ADDR_W-1:0]  rs1_addr,
	input  wire [`REG_ADDR_W-1:0]  rs2_addr,
	input  wire [`REG_ADDR_W-1:0]  rd_addr,
	input  wire [`XLEN-1:0]        rd_data,
	input  wire                    rd_we,
	output logic [`XLEN-1:0]       rs1_data,
	output logic [`XLEN-1:0]       rs2_data
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:31];
	logic [31:0] wr_sel;

	// one-hot write select, also used for the write-through bypass
	assign wr_sel = rd_we ? (32'd1 << rd_addr) : 32'd0;

	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0)
			read_port = '0;
		else if (wr_sel[addr])
			read_port = rd_data;
		else
			read_port = regs[addr];
	endfunction

	always_comb rs1_data = read_port(rs1_addr);
	always_comb rs2_data = read_port(rs2_addr);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 1; i < 32; i++) begin
				if (wr_sel[i])
					regs[i] <= rd_data;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_core (
	input  wire               clock,
	input  wire               reset,
	output logic [`XLEN-1:0]  pc,
	input  wire [`XLEN-1:0]   instr,
	output logic [`XLEN-1:0]  data_addr,
	output logic              ren,
	output logic              wen,
	output logic [`XLEN-1:0]  data_out,
	input  wire [`XLEN-1:0]   data_in
);

	logic stall;
	logic [`XLEN-1:0] if_id_instr;

	// decode stage
	logic [`REG_ADDR_W-1:0] id_rs1, id_rs2, id_rd;
	logic [`XLEN-1:0] id_imm, id_rs1_data, id_rs2_data;
	rv_core_pkg::alu_op_e id_alu_op;
	logic id_use_imm, id_reg_write, id_mem_read, id_mem_write;

	// decode/execute register
	logic [`REG_ADDR_W-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
	logic [`XLEN-1:0] id_ex_imm, id_ex_rs1_data, id_ex_rs2_data;
	rv_core_pkg::alu_op_e id_ex_alu_op;
	logic id_ex_use_imm, id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;

	// execute stage
	rv_core_pkg::fwd_sel_e fwd_a, fwd_b;
	logic [`XLEN-1:0] ex_op_a, ex_op_b, ex_alu_b, ex_result;

	// execute/memory and memory/writeback registers
	logic [`REG_ADDR_W-1:0] ex_mem_rd, mem_wb_rd;
	logic [`XLEN-1:0] ex_mem_result, ex_mem_store_data;
	logic ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;
	logic [`XLEN-1:0] mem_wb_result, mem_wb_load_data, wb_data;
	logic mem_wb_reg_write, mem_wb_mem_read;

	function automatic logic [`XLEN-1:0] fwd_mux(
		input rv_core_pkg::fwd_sel_e sel,
		input logic [`XLEN-1:0]      rf_value,
		input logic [`XLEN-1:0]      mem_value,
		input logic [`XLEN-1:0]      wb_value
	);
		case (sel)
			rv_core_pkg::FWD_EX_MEM: fwd_mux = mem_value;
			rv_core_pkg::FWD_WB:     fwd_mux = wb_value;
			default:                 fwd_mux = rf_value;
		endcase
	endfunction

	// fetch, held together with if_id on a load-use stall
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= `RESET_PC;
			if_id_instr <= `NOP_INSTR;
		end else if (!stall) begin
			pc <= pc + `XLEN'd4;
			if_id_instr <= instr;
		end
	end

	decoder u_decoder (
		.instr(if_id_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
		.alu_op(id_alu_op), .use_imm(id_use_imm), .reg_write(id_reg_write),
		.mem_read(id_mem_read), .mem_write(id_mem_write)
	);

	reg_file u_reg_file (
		.clock(clock), .reset(reset), .rs1_addr(id_rs1), .rs2_addr(id_rs2),
		.rd_addr(mem_wb_rd), .rd_data(wb_data), .rd_we(mem_wb_reg_write),
		.rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
	);

	hazard_unit u_hazard_unit (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(id_ex_rs1), .ex_rs2(id_ex_rs2),
		.ex_rd(id_ex_rd), .ex_mem_read(id_ex_mem_read), .mem_rd(ex_mem_rd),
		.mem_reg_write(ex_mem_reg_write), .mem_mem_read(ex_mem_mem_read),
		.wb_rd(mem_wb_rd), .wb_reg_write(mem_wb_reg_write),
		.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	// a stall turns the execute slot into a bubble
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_ex_rs1 <= '0;
			id_ex_rs2 <= '0;
			id_ex_rd <= '0;
			id_ex_alu_op <= rv_core_pkg::ALU_ADD;
			id_ex_use_imm <= 1'b0;
			id_ex_reg_write <= 1'b0;
			id_ex_mem_read <= 1'b0;
			id_ex_mem_write <= 1'b0;
		end else begin
			id_ex_rs1 <= stall ? '0 : id_rs1;
			id_ex_rs2 <= stall ? '0 : id_rs2;
			id_ex_rd <= stall ? '0 : id_rd;
			id_ex_alu_op <= id_alu_op;
			id_ex_use_imm <= id_use_imm;
			id_ex_reg_write <= id_reg_write && !stall;
			id_ex_mem_read <= id_mem_read && !stall;
			id_ex_mem_write <= id_mem_write && !stall;
		end
	end

	always_ff @(posedge clock) begin
		id_ex_imm <= id_imm;
		id_ex_rs1_data <= id_rs1_data;
		id_ex_rs2_data <= id_rs2_data;
	end

	assign ex_op_a = fwd_mux(fwd_a, id_ex_rs1_data, ex_mem_result, wb_data);
	assign ex_op_b = fwd_mux(fwd_b, id_ex_rs2_data, ex_mem_result, wb_data);
	assign ex_alu_b = id_ex_use_imm ? id_ex_imm : ex_op_b;

	alu u_alu (.a(ex_op_a), .b(ex_alu_b), .op(id_ex_alu_op), .result(ex_result));

	// one shared address bus, a load in execute takes it
	assign ren = id_ex_mem_read;
	assign data_addr = ren ? ex_result : ex_mem_result;
	assign wen = ex_mem_mem_write;
	assign data_out = ex_mem_store_data;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_mem_rd <= '0;
			ex_mem_reg_write <= 1'b0;
			ex_mem_mem_read <= 1'b0;
			ex_mem_mem_write <= 1'b0;
			mem_wb_rd <= '0;
			mem_wb_reg_write <= 1'b0;
			mem_wb_mem_read <= 1'b0;
		end else begin
			ex_mem_rd <= id_ex_rd;
			ex_mem_reg_write <= id_ex_reg_write;
			ex_mem_mem_read <= id_ex_mem_read;
			ex_mem_mem_write <= id_ex_mem_write;
			mem_wb_rd <= ex_mem_rd;
			mem_wb_reg_write <= ex_mem_reg_write;
			mem_wb_mem_read <= ex_mem_mem_read;
		end
	end

	// load data arrives while the load is in memory
	always_ff @(posedge clock) begin
		ex_mem_result <= ex_result;
		ex_mem_store_data <= ex_op_b;
		mem_wb_result <= ex_mem_result;
		mem_wb_load_data <= data_in;
	end

	assign wb_data = mem_wb_mem_read ? mem_wb_load_data : mem_wb_result;

endmodule

`default_nettype wire

/* hw/rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data path and address width
`define XLEN 32

// register index width, 32 integer registers
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* hw/rv_core_pkg.sv */
`default_nettype none
`include "rv_core_macros.svh"

package rv_core_pkg;

	// major opcodes of the supported instructions
	typedef enum logic [6:0] {
		OPC_OTHER  = 7'b0000000,
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_e;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		FWD_RF     = 2'd0,
		FWD_EX_MEM = 2'd1,
		FWD_WB     = 2'd2
	} fwd_sel_e;

endpackage

`default_nettype wire

/* sim/core_checker.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_macros.svh"

module core_checker (
	input  wire              clock,
	input  wire              reset,
	input  wire [`XLEN-1:0]  pc,
	input  wire              ren,
	input  wire              wen,
	input  wire [`XLEN-1:0]  data_addr,
	input  wire [`XLEN-1:0]  data_out,
	input  logic [`XLEN-1:0] prog [0:63],
	input  logic [`XLEN-1:0] init_mem [0:15],
	input  wire              drained,
	output int               errors
);

	logic [`XLEN-1:0] exp_addr [0:63];
	logic [`XLEN-1:0] exp_data [0:63];
	logic [`XLEN-1:0] exp_load [0:63];
	logic [`XLEN-1:0] last_pc;
	int exp_count;
	int store_idx;
	int load_count;
	int load_idx;
	int hold;
	bit reset_prev;

	// in-order ISA model that fills the expected load and store streams
	function automatic int run_reference();
		logic [`XLEN-1:0] regs [0:31];
		logic [`XLEN-1:0] mem [0:15];
		logic [`XLEN-1:0] ins, a, b, addr;
		int n;
		int nl;
		n = 0;
		nl = 0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 16; i++)
			mem[i] = init_mem[i];
		for (int k = 0; k < 64; k++) begin
			ins = prog[k];
			a = regs[ins[19:15]];
			b = regs[ins[24:20]];
			case (ins[6:0])
				// register-register ops
				7'b0110011: begin
					case (ins[14:12])
						3'b000: regs[ins[11:7]] = ins[30] ? a - b : a + b;
						3'b010: regs[ins[11:7]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'b100: regs[ins[11:7]] = a ^ b;
						3'b110: regs[ins[11:7]] = a | b;
						default: regs[ins[11:7]] = a & b;
					endcase
				end
				7'b0010011: regs[ins[11:7]] = a + {{20{ins[31]}}, ins[31:20]};
				7'b0000011: begin
					addr = a + {{20{ins[31]}}, ins[31:20]};
					regs[ins[11:7]] = mem[addr[5:2]];
					exp_load[nl] = addr;
					nl++;
				end
				7'b0100011: begin
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					mem[addr[5:2]] = b;
					exp_addr[n] = addr;
					exp_data[n] = b;
					n++;
				end
				default: ;
			endcase
			regs[0] = '0;
		end
		load_count = nl;
		return n;
	endfunction

	function automatic bit reads_reg(input logic [31:0] ins, input logic [4:0] r);
		bit rs2_used;
		rs2_used = (ins[6:0] == 7'b0110011) || (ins[6:0] == 7'b0100011);
		return (ins[19:15] == r) || (rs2_used && (ins[24:20] == r));
	endfunction

	// one extra cycle at p when p-8 holds a lw used at p-4
	function automatic int expected_hold(input logic [31:0] p);
		int j;
		j = int'(p >> 2) - 2;
		if (j < 0 || j > 62)
			return 0;
		if (prog[j][6:0] == 7'b0000011 && prog[j][11:7] != 5'd0 &&
			reads_reg(prog[j + 1], prog[j][11:7]))
			return 1;
		return 0;
	endfunction

	initial begin
		errors = 0;
		exp_count = 0;
		store_idx = 0;
		load_count = 0;
		load_idx = 0;
		hold = 0;
		reset_prev = 1'b1;
		@(posedge reset);
		exp_count = run_reference();
	end

	always @(negedge clock) begin
		if (!reset || reset_prev) begin
			if (pc !== `RESET_PC) begin
				$display("Mismatch reset_pc: expected %h, actual %h", `RESET_PC, pc);
				errors++;
			end
			if (ren !== 1'b0 || wen !== 1'b0) begin
				$display("memory strobe active during or right after reset");
				errors++;
			end
		end else if (pc === last_pc) begin
			hold++;
			if (hold > expected_hold(pc)) begin
				$display("pc stuck at %h with no load-use pair ahead of it", pc);
				errors++;
			end
		end else begin
			if (pc !== last_pc + 32'd4) begin
				$display("Mismatch pc_step: expected %h, actual %h", last_pc + 32'd4, pc);
				errors++;
			end
			if (hold < expected_hold(last_pc)) begin
				$display("Mismatch load_use_hold at %h: expected %0d, actual %0d",
					last_pc, expected_hold(last_pc), hold);
				errors++;
			end
			hold = 0;
		end
		reset_prev = !reset;
		last_pc = pc;

		// store stream in program order
		if (reset && wen === 1'b1) begin
			if (store_idx >= exp_count) begin
				$display("extra store to %h after all %0d expected stores", data_addr, exp_count);
				errors++;
			end else begin
				if (data_addr !== exp_addr[store_idx]) begin
					$display("Mismatch store_addr[%0d]: expected %h, actual %h",
						store_idx, exp_addr[store_idx], data_addr);
					errors++;
				end
				if (data_out !== exp_data[store_idx]) begin
					$display("Mismatch store_data[%0d]: expected %h, actual %h",
						store_idx, exp_data[store_idx], data_out);
					errors++;
				end
			end
			store_idx++;
		end

		// one read strobe per lw, in program order
		if (reset && ren === 1'b1) begin
			if (load_idx >= load_count) begin
				$display("extra load from %h after all %0d expected loads",
					data_addr, load_count);
				errors++;
			end else if (data_addr !== exp_load[load_idx]) begin
				$display("Mismatch load_addr[%0d]: expected %h, actual %h",
					load_idx, exp_load[load_idx], data_addr);
				errors++;
			end
			load_idx++;
		end
	end

	always @(posedge drained) begin
		if (store_idx < exp_count) begin
			$display("missing stores, only %0d of %0d seen", store_idx, exp_count);
			errors++;
		end
		if (load_idx < load_count) begin
			$display("missing loads, only %0d of %0d seen", load_idx, load_count);
			errors++;
		end
	end

endmodule

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_macros.svh"

module tb_rv_core;

	localparam int PROG_LEN = 64;
	localparam int MAX_CYCLES = PROG_LEN * 2 + 40;

	logic clock;
	logic reset;
	logic [`XLEN-1:0] pc, instr, data_addr, data_out, data_in;
	logic ren, wen;
	logic drained;
	int checker_errors;
	int cycles;
	integer seed;
	logic [`XLEN-1:0] prog [0:PROG_LEN-1];
	logic [`XLEN-1:0] init_mem [0:15];
	logic [`XLEN-1:0] data_mem [0:15];

	rv_core u_dut (
		.clock(clock), .reset(reset), .pc(pc), .instr(instr), .data_addr(data_addr),
		.ren(ren), .wen(wen), .data_out(data_out), .data_in(data_in)
	);

	core_checker u_checker (
		.clock(clock), .reset(reset), .pc(pc), .ren(ren), .wen(wen),
		.data_addr(data_addr), .data_out(data_out), .prog(prog),
		.init_mem(init_mem), .drained(drained), .errors(checker_errors)
	);

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// small register set keeps dependencies dense
	function automatic logic [4:0] pick_reg();
		return 5'($unsigned($random(seed)) % 8);
	endfunction

	// word offset inside the 16-word data region, based on x0
	function automatic logic [11:0] pick_offset();
		return 12'(($unsigned($random(seed)) % 16) * 4);
	endfunction

	function automatic logic [31:0] random_alu_op(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		case ($unsigned($random(seed)) % 6)
			0: return r_type(7'h00, rs2, rs1, 3'b000, rd);
			1: return r_type(7'h20, rs2, rs1, 3'b000, rd);
			2: return r_type(7'h00, rs2, rs1, 3'b111, rd);
			3: return r_type(7'h00, rs2, rs1, 3'b110, rd);
			4: return r_type(7'h00, rs2, rs1, 3'b100, rd);
			default: return r_type(7'h00, rs2, rs1, 3'b010, rd);
		endcase
	endfunction

	task automatic build_program();
		int k;
		int kind;
		logic [4:0] rd;
		bit prev_sw;
		k = 0;
		prev_sw = 1'b0;
		for (int i = 0; i < 16; i++) begin
			init_mem[i] = (i * 32'h9e37_79b1) ^ 32'hc3a5_0000 ^ (i * 4);
			data_mem[i] = init_mem[i];
		end
		while (k < PROG_LEN) begin
			kind = $unsigned($random(seed)) % 6;
			// a lw right behind a sw would share the address bus with it
			if ((kind == 3 || kind == 5) && prev_sw)
				kind = 0;
			if (kind == 5 && k == PROG_LEN - 1)
				kind = 3;
			case (kind)
				0: prog[k] = i_type(12'($random(seed)), pick_reg(), 3'b000, pick_reg(),
					7'b0010011);
				1, 2: prog[k] = random_alu_op(pick_reg(), pick_reg(), pick_reg());
				3: prog[k] = i_type(pick_offset(), 5'd0, 3'b010, pick_reg(), 7'b0000011);
				4: prog[k] = s_type(pick_offset(), pick_reg());
				default: begin
					rd = 5'd1 + 5'($unsigned($random(seed)) % 7);
					prog[k] = i_type(pick_offset(), 5'd0, 3'b010, rd, 7'b0000011);
					k++;
					prog[k] = random_alu_op(pick_reg(), pick_reg(), rd);
				end
			endcase
			prev_sw = (kind == 4);
			k++;
		end
	endtask

	task automatic finish_run(input bit timed_out);
		$display("closing report: %0d checker errors, %0d timeout errors",
			checker_errors, timed_out);
		if (checker_errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	// instruction ROM answers pc in the same cycle
	assign instr = (pc[31:2] < PROG_LEN) ? prog[pc[7:2]] : `NOP_INSTR;

	always @(posedge clock) begin
		if (ren)
			data_in <= data_mem[data_addr[5:2]];
		if (wen)
			data_mem[data_addr[5:2]] <= data_out;
	end

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, program not drained after %0d cycles", MAX_CYCLES);
			finish_run(1'b1);
		end
	end

	initial begin
		seed = 32'h7b45ce99;
		cycles = 0;
		reset = 1'b0;
		drained = 1'b0;
		data_in = '0;
		build_program();
		repeat (5) @(posedge clock);
		reset <= 1'b1;
		// last instruction is past writeback once pc is this far beyond it
		while (pc < PROG_LEN * 4 + 20)
			@(posedge clock);
		drained <= 1'b1;
		@(posedge clock);
		finish_run(1'b0);
	end

endmodule

`default_nettype wire
